// ==== Makefile ====
# Verilator build and run of the instrument core testbench
TOP := tb_rp_top

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf obj_dir

// ==== analog_io/adc_frontend.sv ====
// fast ADC capture, two channels, new sample every cycle
// raw code is negative slope, the two low bits are unused by the 14 bit part

`timescale 1ns/1ps

`include "rp_defines.svh"

module adc_frontend (
  input  logic                     adc_clk,
  input  logic                     rst_n_i,
  input  rp_sample_pkg::adc_raw_t  adc_dat_a_i,     // raw pins
  input  rp_sample_pkg::adc_raw_t  adc_dat_b_i,
  input  rp_sample_pkg::sample_t   dac_a_i,         // saturated DAC samples
  input  rp_sample_pkg::sample_t   dac_b_i,
  input  logic                     digital_loop_i,  // loopback enable
  output rp_sample_pkg::sample_t   adc_a_o,
  output rp_sample_pkg::sample_t   adc_b_o
);

  import rp_sample_pkg::*;

  // drop reserved bits, keep sign, flip magnitude
  function automatic sample_t raw_to_smp(input adc_raw_t raw);
    logic [`RP_SMP_W-1:0] top;
    top = raw[`RP_ADC_RAW_W-1:`RP_ADC_RSV];
    return {top[`RP_SMP_W-1], ~top[`RP_SMP_W-2:0]};
  endfunction

  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      adc_a_o <= '0;
      adc_b_o <= '0;
    end
    else
    begin
      // loopback replaces the pins with the DAC stream
      adc_a_o <= digital_loop_i ? dac_a_i : raw_to_smp(adc_dat_a_i);
      adc_b_o <= digital_loop_i ? dac_b_i : raw_to_smp(adc_dat_b_i);
    end
  end

endmodule

// ==== analog_io/dac_backend.sv ====
// DAC output stage, asg + pid per channel
// sum saturates to the 14 bit range, pins get negative slope offset binary
// dac_*_o are combinational for the ADC loopback

`timescale 1ns/1ps

`include "rp_defines.svh"

module dac_backend (
  input  logic                    adc_clk,
  input  logic                    rst_n_i,
  input  rp_sample_pkg::sample_t  asg_a_i,      // generator
  input  rp_sample_pkg::sample_t  asg_b_i,
  input  rp_sample_pkg::sample_t  pid_a_i,      // controller
  input  rp_sample_pkg::sample_t  pid_b_i,
  output rp_sample_pkg::sample_t  dac_a_o,      // saturated, unregistered
  output rp_sample_pkg::sample_t  dac_b_o,
  output logic [`RP_SMP_W-1:0]    dac_dat_a_o,  // to the DAC pins
  output logic [`RP_SMP_W-1:0]    dac_dat_b_o
);

  import rp_sample_pkg::*;

  sum_t sum_a;
  sum_t sum_b;

  ////////////////////
  // helpers
  ////////////////////

  // clip to +8191/-8192 when the two top bits disagree
  function automatic sample_t saturate(input sum_t s);
    if (s[`RP_SUM_W-1] ^ s[`RP_SUM_W-2])
      return {s[`RP_SUM_W-1], {(`RP_SMP_W-1){~s[`RP_SUM_W-1]}}};
    else
      return s[`RP_SMP_W-1:0];
  endfunction

  // sign stays, magnitude inverted
  function automatic logic [`RP_SMP_W-1:0] to_dac(input sample_t s);
    return {s[`RP_SMP_W-1], ~s[`RP_SMP_W-2:0]};
  endfunction

  ////////////////////
  // sum and clip
  ////////////////////

  assign sum_a = sum_t'(asg_a_i) + sum_t'(pid_a_i);  // sign extended
  assign sum_b = sum_t'(asg_b_i) + sum_t'(pid_b_i);

  assign dac_a_o = saturate(sum_a);
  assign dac_b_o = saturate(sum_b);

  // output registers
  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      dac_dat_a_o <= to_dac('0);  // mid scale
      dac_dat_b_o <= to_dac('0);
    end
    else
    begin
      dac_dat_a_o <= to_dac(dac_a_o);
      dac_dat_b_o <= to_dac(dac_b_o);
    end
  end

endmodule

// ==== common/rp_bus_pkg.sv ====
// system bus address views
// region field sits at RP_REGION_LSB, the rest below it is the in-region offset

`include "rp_defines.svh"

package rp_bus_pkg;

  // region index, one of RP_REGIONS
  typedef logic [`RP_REGION_W-1:0] region_t;

  // address split into fields
  typedef struct packed {
    logic [`RP_BUS_W-`RP_REGION_W-`RP_REGION_LSB-1:0] upper;   // ignored by the decoder
    region_t                                          region;  // slave select
    logic [`RP_REGION_LSB-1:0]                        offset;  // register offset
  } sys_addr_s;

  // one address word, two decodes
  //  region view for the decoder
  //  offset view for the slaves
  typedef union packed {
    logic [`RP_BUS_W-1:0] word;  // raw address as driven by the master
    sys_addr_s            f;     // field view
  } sys_addr_u;

endpackage

// ==== common/rp_defines.svh ====
// board constants for the two-channel instrument core
// widths are fixed by the ADC/DAC parts and are not meant to be changed
// bus offsets are byte addresses inside one 1 MB region

`ifndef RP_DEFINES_SVH
`define RP_DEFINES_SVH

// fast ADC/DAC words
`define RP_ADC_RAW_W 16              // raw ADC word from the pins
`define RP_ADC_RSV 2                 // reserved low bits of the raw word
`define RP_SMP_W 14                  // sample width
`define RP_SUM_W 15                  // asg + pid before saturation

// system bus
`define RP_BUS_W 32                  // address and data width
`define RP_REGIONS 8                 // 1 MB each
`define RP_REGION_LSB 20             // region field position
`define RP_REGION_W 3                // region field width

// housekeeping map
`define RP_HK_ID_OFS 20'h0_0000      // read only
`define RP_HK_LOOP_OFS 20'h0_0004    // bit 0 is the loopback enable
`define RP_HK_ID 32'h5250_0001       // design id word

`endif

// ==== common/rp_sample_pkg.sv ====
// sample types for the fast analog paths
// all samples are two's complement inside the core

`include "rp_defines.svh"

package rp_sample_pkg;

  // signed sample as seen by the processing blocks
  typedef logic signed [`RP_SMP_W-1:0] sample_t;

  // asg + pid sum, one guard bit for the overflow check
  typedef logic signed [`RP_SUM_W-1:0] sum_t;

  // raw ADC pin word
  // negative slope code, reserved bits at the bottom
  typedef logic [`RP_ADC_RAW_W-1:0] adc_raw_t;

endpackage

// ==== compile.f ====
+incdir+common
common/rp_bus_pkg.sv
common/rp_sample_pkg.sv
sys_bus/sys_bus_decoder.sv
hdl/housekeeping.sv
analog_io/adc_frontend.sv
analog_io/dac_backend.sv
hdl/rp_top.sv
verif/rp_top_asserts.sv
verif/tb_rp_top.sv

// ==== hdl/housekeeping.sv ====
// housekeeping registers on bus region 0
// answers every strobe one cycle later, unmapped offsets get err

`timescale 1ns/1ps

`include "rp_defines.svh"

module housekeeping (
  input  logic                  adc_clk,
  input  logic                  rst_n_i,
  input  rp_bus_pkg::sys_addr_u sys_addr_i,     // offset view used here
  input  logic [`RP_BUS_W-1:0]  sys_wdata_i,
  input  logic                  sys_wen_i,      // already region gated
  input  logic                  sys_ren_i,
  output logic [`RP_BUS_W-1:0]  sys_rdata_o,
  output logic                  sys_ack_o,
  output logic                  sys_err_o,
  output logic                  digital_loop_o  // ADC input from DAC
);

  logic [`RP_REGION_LSB-1:0] ofs;
  logic                      strobe;
  logic                      hit_id;
  logic                      hit_loop;

  assign ofs      = sys_addr_i.f.offset;
  assign strobe   = sys_wen_i | sys_ren_i;
  assign hit_id   = (ofs == `RP_HK_ID_OFS);
  assign hit_loop = (ofs == `RP_HK_LOOP_OFS);

  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      digital_loop_o <= 1'b0;
      sys_ack_o      <= 1'b0;
      sys_err_o      <= 1'b0;
      sys_rdata_o    <= '0;
    end
    else
    begin
      if (sys_wen_i && hit_loop)
        digital_loop_o <= sys_wdata_i[0];  // writes to the id are dropped
      sys_ack_o <= strobe;
      sys_err_o <= strobe & ~(hit_id | hit_loop);  // unmapped
      if (sys_ren_i && hit_id)
        sys_rdata_o <= `RP_HK_ID;
      else if (sys_ren_i && hit_loop)
        sys_rdata_o <= {{(`RP_BUS_W-1){1'b0}}, digital_loop_o};
      else
        sys_rdata_o <= '0;  // writes and bad offsets return 0
    end
  end

endmodule

// ==== hdl/rp_top.sv ====
// two-channel instrument core, everything on adc_clk
// asg/pid streams come from outside, adc_*_o feed the external consumers
// bus regions 1 to 7 are empty and ack at once

`timescale 1ns/1ps

`include "rp_defines.svh"

module rp_top (
  input  logic                     adc_clk,
  input  logic                     rst_n_i,
  // fast analog
  input  rp_sample_pkg::adc_raw_t  adc_dat_a_i,
  input  rp_sample_pkg::adc_raw_t  adc_dat_b_i,
  input  rp_sample_pkg::sample_t   asg_a_i,
  input  rp_sample_pkg::sample_t   asg_b_i,
  input  rp_sample_pkg::sample_t   pid_a_i,
  input  rp_sample_pkg::sample_t   pid_b_i,
  output rp_sample_pkg::sample_t   adc_a_o,
  output rp_sample_pkg::sample_t   adc_b_o,
  output logic [`RP_SMP_W-1:0]     dac_dat_a_o,
  output logic [`RP_SMP_W-1:0]     dac_dat_b_o,
  // system bus
  input  rp_bus_pkg::sys_addr_u    sys_addr_i,
  input  logic [`RP_BUS_W-1:0]     sys_wdata_i,
  input  logic                     sys_wen_i,
  input  logic                     sys_ren_i,
  output logic [`RP_BUS_W-1:0]     sys_rdata_o,
  output logic                     sys_ack_o,
  output logic                     sys_err_o
);

  import rp_sample_pkg::*;

  logic                 hk_wen;
  logic                 hk_ren;
  logic [`RP_BUS_W-1:0] hk_rdata;
  logic                 hk_ack;
  logic                 hk_err;
  logic                 digital_loop;
  sample_t              dac_a;         // loopback taps
  sample_t              dac_b;

  ////////////////////
  // bus
  ////////////////////

  sys_bus_decoder u_dec (
    .sys_addr_i  (sys_addr_i),  .sys_wen_i  (sys_wen_i),  .sys_ren_i (sys_ren_i),
    .hk_rdata_i  (hk_rdata),    .hk_ack_i   (hk_ack),     .hk_err_i  (hk_err),
    .hk_wen_o    (hk_wen),      .hk_ren_o   (hk_ren),
    .sys_rdata_o (sys_rdata_o), .sys_ack_o  (sys_ack_o),  .sys_err_o (sys_err_o)
  );

  housekeeping u_hk (
    .adc_clk     (adc_clk),     .rst_n_i    (rst_n_i),
    .sys_addr_i  (sys_addr_i),  .sys_wdata_i (sys_wdata_i),
    .sys_wen_i   (hk_wen),      .sys_ren_i  (hk_ren),                // region 0 only
    .sys_rdata_o (hk_rdata),    .sys_ack_o  (hk_ack),    .sys_err_o (hk_err),
    .digital_loop_o (digital_loop)
  );

  ////////////////////
  // analog stages
  ////////////////////

  adc_frontend u_adc (
    .adc_clk     (adc_clk),     .rst_n_i    (rst_n_i),
    .adc_dat_a_i (adc_dat_a_i), .adc_dat_b_i (adc_dat_b_i),
    .dac_a_i     (dac_a),       .dac_b_i    (dac_b),
    .digital_loop_i (digital_loop),
    .adc_a_o     (adc_a_o),     .adc_b_o    (adc_b_o)
  );

  dac_backend u_dac (
    .adc_clk     (adc_clk),     .rst_n_i    (rst_n_i),
    .asg_a_i     (asg_a_i),     .asg_b_i    (asg_b_i),
    .pid_a_i     (pid_a_i),     .pid_b_i    (pid_b_i),
    .dac_a_o     (dac_a),       .dac_b_o    (dac_b),
    .dac_dat_a_o (dac_dat_a_o), .dac_dat_b_o (dac_dat_b_o)
  );

endmodule

// ==== sys_bus/sys_bus_decoder.sv ====
// combinational system bus decoder, 8 regions of 1 MB
// only region 0 (housekeeping) is populated
// the master must hold the address until ack, the select follows it

`timescale 1ns/1ps

`include "rp_defines.svh"

module sys_bus_decoder (
  input  rp_bus_pkg::sys_addr_u  sys_addr_i,   // master address
  input  logic                   sys_wen_i,    // write strobe
  input  logic                   sys_ren_i,    // read strobe
  input  logic [`RP_BUS_W-1:0]   hk_rdata_i,   // housekeeping answer
  input  logic                   hk_ack_i,
  input  logic                   hk_err_i,
  output logic                   hk_wen_o,     // region 0 strobes
  output logic                   hk_ren_o,
  output logic [`RP_BUS_W-1:0]   sys_rdata_o,  // back to master
  output logic                   sys_ack_o,
  output logic                   sys_err_o
);

  import rp_bus_pkg::*;

  region_t                 region;                    // selected slave
  logic [`RP_REGIONS-1:0]  cs;                        // one hot
  logic [`RP_REGIONS-1:0]  wen;
  logic [`RP_REGIONS-1:0]  ren;
  logic [`RP_REGIONS-1:0]  ack;
  logic [`RP_REGIONS-1:0]  err;
  logic [`RP_BUS_W-1:0]    rdata [`RP_REGIONS];

  ////////////////////
  // select and strobes
  ////////////////////

  assign region = sys_addr_i.f.region;
  assign cs     = `RP_REGIONS'(1) << region;

  assign wen = cs & {`RP_REGIONS{sys_wen_i}};
  assign ren = cs & {`RP_REGIONS{sys_ren_i}};

  // region 0 is housekeeping
  assign hk_wen_o = wen[0];
  assign hk_ren_o = ren[0];
  assign rdata[0] = hk_rdata_i;
  assign ack[0]   = hk_ack_i;    // arrives one cycle after the strobe
  assign err[0]   = hk_err_i;

  // empty slots answer right away
  for (genvar i = 1; i < `RP_REGIONS; i++)
  begin : g_unused
    assign rdata[i] = '0;
    assign ack[i]   = wen[i] | ren[i];  // same cycle ack
    assign err[i]   = 1'b0;
  end

  ////////////////////
  // return mux
  ////////////////////

  assign sys_rdata_o = rdata[region];
  assign sys_ack_o   = |(cs & ack);
  assign sys_err_o   = |(cs & err);

endmodule

// ==== verif/rp_cases.txt ====
# name kind f0 f1 f2 f3 f4 f5, fields in hex
# adc: raw_a raw_b exp_a exp_b    dac, loop: asg_a pid_a asg_b pid_b exp_a exp_b
# rd, wr: addr wdata exp_rdata exp_err ack_cycles    radc, rdac: drawn at random
adc_zero    adc   0000 ffff 1fff 2000 0 0
adc_rsv     adc   0003 8002 1fff 3fff 0 0
radc_1      radc  0 0 0 0 0 0
dac_small   dac   0064 0032 3f9c 0000 1f69 2063
dac_satp    dac   1fff 0001 1000 1000 0000 0000
dac_satn    dac   2000 3fff 3000 3000 3fff 3fff
rdac_1      rdac  0 0 0 0 0 0
hk_id       rd    00000000 0 52500001 0 1 0
reg1_rd     rd    00100000 0 0 0 0 0
reg7_wr     wr    00700004 1 0 0 0 0
reg3_upper  rd    80300000 0 0 0 0 0
hk_loop_rd0 rd    00000004 0 0 0 1 0
hk_bad_rd   rd    00000010 0 0 1 1 0
hk_bad_wr   wr    00000008 1 0 1 1 0
loop_on     wr    00000004 1 0 0 1 0
loop_rd1    rd    00000004 0 1 0 1 0
loop_sum    loop  0064 0032 3f9c 0000 0096 3f9c
loop_sat    loop  1fff 0001 2000 3fff 1fff 2000
loop_off    wr    00000004 0 0 0 1 0
adc_back    adc   0000 7ffc 1fff 0000 0 0

// ==== verif/rp_top_asserts.sv ====
// bus protocol checks on the top level
// assumes the master holds the address until ack

`timescale 1ns/1ps

`include "rp_defines.svh"

module rp_top_asserts (
  input logic                 adc_clk,
  input logic                 rst_n_i,
  input logic [`RP_BUS_W-1:0] sys_addr_i,
  input logic                 sys_wen_i,
  input logic                 sys_ren_i,
  input logic [`RP_BUS_W-1:0] sys_rdata_i,  // top level read data
  input logic                 sys_ack_i,
  input logic                 sys_err_i
);

  logic                    strobe;
  logic [`RP_REGION_W-1:0] region;

  assign strobe = sys_wen_i | sys_ren_i;
  assign region = sys_addr_i[`RP_REGION_LSB +: `RP_REGION_W];

  // same cycle for empty regions, one cycle later for housekeeping
  ack_after_strobe : assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    sys_ack_i |-> (strobe || $past(strobe)))
    else $error("ack with no strobe in this or the previous cycle");

  err_implies_ack : assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    sys_err_i |-> sys_ack_i)
    else $error("err without ack");

  unused_rdata_zero : assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    (sys_ack_i && region != '0) |-> (sys_rdata_i == '0))
    else $error("empty region returned nonzero data");

endmodule

bind rp_top rp_top_asserts u_asserts (
  .adc_clk     (adc_clk),
  .rst_n_i     (rst_n_i),
  .sys_addr_i  (sys_addr_i),
  .sys_wen_i   (sys_wen_i),
  .sys_ren_i   (sys_ren_i),
  .sys_rdata_i (sys_rdata_o),
  .sys_ack_i   (sys_ack_o),
  .sys_err_i   (sys_err_o)
);

// ==== verif/tb_rp_top.sv ====
// run from the project root so that verif/rp_cases.txt is found
// bus cases hold the address until ack
// outputs are sampled on the falling edge
// random cases use a fixed seed, so every run draws the same operands

`timescale 1ns/1ps

`include "rp_defines.svh"

module tb_rp_top;

  import rp_sample_pkg::*;
  import rp_bus_pkg::*;

  localparam int RST_CYCLES = 8;
  localparam int MAX_CASES  = 64;

  logic                      adc_clk;
  logic                      rst_n_i;
  adc_raw_t                  adc_dat_a_i;
  adc_raw_t                  adc_dat_b_i;
  sample_t                   asg_a_i;
  sample_t                   asg_b_i;
  sample_t                   pid_a_i;
  sample_t                   pid_b_i;
  sample_t                   adc_a_o;
  sample_t                   adc_b_o;
  logic [`RP_SMP_W-1:0]      dac_dat_a_o;
  logic [`RP_SMP_W-1:0]      dac_dat_b_o;
  sys_addr_u                 sys_addr_i;
  logic [`RP_BUS_W-1:0]      sys_wdata_i;
  logic                      sys_wen_i;
  logic                      sys_ren_i;
  logic [`RP_BUS_W-1:0]      sys_rdata_o;
  logic                      sys_ack_o;
  logic                      sys_err_o;

  string       names [MAX_CASES];   // from the case file
  string       kinds [MAX_CASES];
  logic [31:0] fld   [MAX_CASES][6];
  logic [31:0] cur   [6];           // fields of the running case
  string       cur_name;
  string       kind;
  int          n_cases = 0;
  int          limit   = 0;         // 0 until the file is read
  int          cycles  = 0;
  int          errors  = 0;
  int          case_err;
  int          n_pass  = 0;
  int          n_fail  = 0;
  integer      seed    = 2581;
  integer      r;

  rp_top dut0 (.*);

  ////////////////////
  // clock and timeout
  ////////////////////

  initial
  begin
    adc_clk = 1'b0;
    forever #20 adc_clk = ~adc_clk;  // 40 ns
  end

  initial
  begin
    while (!(limit > 0 && cycles > limit))
    begin
      @(posedge adc_clk);
      cycles++;
    end
    $display("run stopped after %0d cycles, the cases did not finish", cycles);
    $display("Test FAILED");
    $finish;
  end

  ////////////////////
  // reference model
  ////////////////////

  function automatic logic [31:0] widen(input logic [13:0] v);
    return {18'd0, v};
  endfunction

  function automatic integer sext14(input logic [13:0] v);
    return {{18{v[13]}}, v};
  endfunction

  // asg + pid clipped to the 14 bit range
  function automatic integer clip_sum(input logic [13:0] a, input logic [13:0] p);
    integer s;
    s = sext14(a) + sext14(p);
    if (s > 8191)
      s = 8191;
    else if (s < -8192)
      s = -8192;
    return s;
  endfunction

  // negative slope offset binary maps +8191 to 0 and -8192 to 16383
  function automatic logic [13:0] dac_code(input integer v);
    integer c;
    c = 8191 - v;
    return c[13:0];
  endfunction

  // top 14 bits t of the raw word map to 8191 - t
  function automatic logic [13:0] adc_conv(input logic [15:0] raw);
    integer t;
    integer v;
    t = {18'd0, raw[15:2]};
    v = 8191 - t;
    return v[13:0];
  endfunction

  ////////////////////
  // checks and stimulus
  ////////////////////

  task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] got);
    if (got !== exp)
    begin
      $display("Fail %s %s: expected %h, got %h", cur_name, what, exp, got);
      case_err++;
      errors++;
    end
  endtask

  task automatic load_cases;
    int          fd;
    int          n;
    string       line;
    string       nm;
    string       kd;
    logic [31:0] f [6];
    fd = $fopen("verif/rp_cases.txt", "r");
    if (fd == 0)
    begin
      $display("cannot open verif/rp_cases.txt");
      errors++;
    end
    else
    begin
      while (!$feof(fd))
      begin
        if ($fgets(line, fd) == 0)
          continue;
        n = $sscanf(line, "%s %s %h %h %h %h %h %h",
                    nm, kd, f[0], f[1], f[2], f[3], f[4], f[5]);
        if (n < 1 || nm.substr(0, 0) == "#")
          continue;  // blank or comment
        if (n != 8 || n_cases == MAX_CASES)
        begin
          $display("case line skipped, wrong field count or table full: %s", line);
          errors++;
          continue;
        end
        names[n_cases] = nm;
        kinds[n_cases] = kd;
        fld[n_cases]   = f;
        n_cases++;
      end
      $fclose(fd);
    end
  endtask

  task automatic run_adc;
    @(posedge adc_clk);
    adc_dat_a_i <= cur[0][15:0];
    adc_dat_b_i <= cur[1][15:0];
    @(posedge adc_clk);  // one cycle latency
    @(negedge adc_clk);
    check_val("adc_a", cur[2], widen(adc_a_o));
    check_val("adc_b", cur[3], widen(adc_b_o));
  endtask

  // with loop set the raw pins are random and must not matter
  task automatic run_streams(input logic loop);
    @(posedge adc_clk);
    asg_a_i <= cur[0][13:0];
    pid_a_i <= cur[1][13:0];
    asg_b_i <= cur[2][13:0];
    pid_b_i <= cur[3][13:0];
    if (loop)
    begin
      r = $random(seed);
      adc_dat_a_i <= r[15:0];
      adc_dat_b_i <= r[31:16];
    end
    @(posedge adc_clk);
    @(negedge adc_clk);
    if (loop)
    begin
      check_val("adc_a", cur[4], widen(adc_a_o));
      check_val("adc_b", cur[5], widen(adc_b_o));
    end
    else
    begin
      check_val("dac_a", cur[4], widen(dac_dat_a_o));
      check_val("dac_b", cur[5], widen(dac_dat_b_o));
    end
  endtask

  // cur holds addr, wdata, rdata, err and the cycles from strobe to ack
  task automatic bus_access(input logic wr);
    int                   lat;
    logic                 got_ack;
    logic                 got_err;
    logic [`RP_BUS_W-1:0] got_rdata;
    @(posedge adc_clk);
    sys_addr_i  <= cur[0];
    sys_wdata_i <= cur[1];
    sys_wen_i   <= wr;
    sys_ren_i   <= ~wr;
    lat = 0;
    @(negedge adc_clk);
    while (!sys_ack_o && lat < 4)
    begin
      @(posedge adc_clk);
      sys_wen_i <= 1'b0;  // single cycle strobe
      sys_ren_i <= 1'b0;
      lat++;
      @(negedge adc_clk);
    end
    got_ack   = sys_ack_o;
    got_err   = sys_err_o;
    got_rdata = sys_rdata_o;
    @(posedge adc_clk);
    sys_wen_i <= 1'b0;
    sys_ren_i <= 1'b0;
    if (!got_ack)
    begin
      $display("%s got no ack within 4 cycles of the strobe", cur_name);
      case_err++;
      errors++;
    end
    else
    begin
      check_val("rdata", cur[2], got_rdata);
      check_val("err", cur[3], {31'd0, got_err});
      check_val("latency", cur[4], lat);
    end
  endtask

  task automatic finish_case;
    if (case_err == 0)
    begin
      n_pass++;
      $display("%s passed", cur_name);
    end
    else
    begin
      n_fail++;
      $display("%s failed with %0d mismatches", cur_name, case_err);
    end
  endtask

  ////////////////////
  // main sequence
  ////////////////////

  initial
  begin
    rst_n_i     = 1'b0;
    adc_dat_a_i = '0;
    adc_dat_b_i = '0;
    asg_a_i     = '0;
    asg_b_i     = '0;
    pid_a_i     = '0;
    pid_b_i     = '0;
    sys_addr_i  = '0;
    sys_wdata_i = '0;
    sys_wen_i   = 1'b0;
    sys_ren_i   = 1'b0;
    load_cases();
    limit = (n_cases + 1) * 8 + RST_CYCLES;  // reset check counts as a case
    repeat (RST_CYCLES) @(posedge adc_clk);
    rst_n_i <= 1'b1;
    // flops still hold their reset values here
    cur_name = "reset_state";
    case_err = 0;
    @(negedge adc_clk);
    check_val("adc_a", 32'd0, widen(adc_a_o));
    check_val("adc_b", 32'd0, widen(adc_b_o));
    check_val("dac_a", widen(dac_code(0)), widen(dac_dat_a_o));
    check_val("dac_b", widen(dac_code(0)), widen(dac_dat_b_o));
    check_val("ack", 32'd0, {31'd0, sys_ack_o});
    check_val("err", 32'd0, {31'd0, sys_err_o});
    finish_case();
    for (int i = 0; i < n_cases; i++)
    begin
      cur_name = names[i];
      kind     = kinds[i];
      cur      = fld[i];
      case_err = 0;
      if (kind == "radc")
      begin
        r = $random(seed);
        cur[0] = {16'd0, r[15:0]};
        cur[1] = {16'd0, r[31:16]};
        cur[2] = widen(adc_conv(r[15:0]));
        cur[3] = widen(adc_conv(r[31:16]));
      end
      if (kind == "rdac")
      begin
        r = $random(seed);
        cur[0] = widen(r[13:0]);
        cur[1] = widen(r[27:14]);
        r = $random(seed);
        cur[2] = widen(r[13:0]);
        cur[3] = widen(r[27:14]);
        cur[4] = widen(dac_code(clip_sum(cur[0][13:0], cur[1][13:0])));
        cur[5] = widen(dac_code(clip_sum(cur[2][13:0], cur[3][13:0])));
      end
      if (kind == "adc" || kind == "radc")
        run_adc();
      else if (kind == "dac" || kind == "rdac")
        run_streams(1'b0);
      else if (kind == "loop")
        run_streams(1'b1);
      else if (kind == "rd" || kind == "wr")
        bus_access(kind == "wr");
      else
      begin
        $display("%s has an unknown kind %s", cur_name, kind);
        case_err++;
        errors++;
      end
      finish_case();
    end
    $display("cases %0d, passed %0d, failed %0d", n_pass + n_fail, n_pass, n_fail);
    if (errors == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

endmodule
